// ==== source/core_axi_pkg.sv ====
package core_axi_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  axi_id_t;

    localparam axi_id_t ID_ICACHE = 4'd0;
    localparam axi_id_t ID_DCACHE = 4'd1;

    localparam int BEATS_DEFAULT = 8; // words per cache line

    typedef logic [BEATS_DEFAULT*$bits(word_t)-1:0] line_t;

    // cache side
    typedef struct packed {
        logic  req;
        addr_t addr;
    } line_rd_req_t;

    typedef struct packed {
        logic  valid; // one-cycle return pulse
        line_t data;
    } line_ret_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
        line_t data;
    } line_wr_req_t;

    // axi channels, len/size/burst/strb fixed
    typedef struct packed {
        logic    valid;
        axi_id_t id;
        addr_t   addr;
    } axi_ar_t;

    typedef struct packed {
        logic    valid;
        axi_id_t id;
        addr_t   addr;
    } axi_aw_t;

    typedef struct packed {
        logic       valid;
        axi_id_t    id;
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        logic       valid;
        axi_id_t    id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

// ==== source/beat_counter.sv ====
module beat_counter #(
    parameter int BEATS = core_axi_pkg::BEATS_DEFAULT
) (
    input  logic aclk,
    input  logic rst,
    input  logic clear_i,
    input  logic beat_i,
    output logic last_beat_o
);
    localparam int CW = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam logic [CW-1:0] LAST = CW'(BEATS - 1);

    logic [CW-1:0] count_q;

    always_ff @(posedge aclk) begin
        if (rst || clear_i) begin
            count_q <= '0;
        end else if (beat_i) begin
            if (count_q == LAST) begin
                count_q <= '0; // wrap for next burst
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign last_beat_o = (count_q == LAST);

endmodule

// ==== source/rd_line_assembler.sv ====
module rd_line_assembler #(
    parameter int BEATS = core_axi_pkg::BEATS_DEFAULT
) (
    input  logic                                         aclk,
    input  logic                                         rst,
    input  logic                                         capture_i,
    input  core_axi_pkg::word_t                          rdata_i,
    output logic [BEATS*$bits(core_axi_pkg::word_t)-1:0] line_o
);
    localparam int WW     = $bits(core_axi_pkg::word_t);
    localparam int LINE_W = BEATS * WW;

    logic [LINE_W-1:0] line_q;

    // new word enters at the top and walks down,
    // so after BEATS captures beat 0 sits in word 0
    always_ff @(posedge aclk) begin
        if (rst) begin
            line_q <= '0;
        end else if (capture_i) begin
            if (BEATS > 1) begin
                line_q <= {rdata_i, line_q[LINE_W-1:WW]};
            end else begin
                line_q <= LINE_W'(rdata_i);
            end
        end
    end

    assign line_o = line_q;

endmodule

// ==== source/wr_line_serializer.sv ====
module wr_line_serializer #(
    parameter int BEATS = core_axi_pkg::BEATS_DEFAULT
) (
    input  logic                                         aclk,
    input  logic                                         rst,
    input  logic                                         load_i,
    input  logic [BEATS*$bits(core_axi_pkg::word_t)-1:0] line_i,
    input  logic                                         advance_i,
    output core_axi_pkg::word_t                          wdata_o
);
    localparam int WW     = $bits(core_axi_pkg::word_t);
    localparam int LINE_W = BEATS * WW;

    logic [LINE_W-1:0] shift_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            shift_q <= '0;
        end else if (load_i) begin
            shift_q <= line_i; // victim line, word 0 goes out first
        end else if (advance_i) begin
            if (BEATS > 1) begin
                shift_q <= {{WW{1'b0}}, shift_q[LINE_W-1:WW]};
            end else begin
                shift_q <= '0;
            end
        end
    end

    assign wdata_o = shift_q[WW-1:0];

endmodule

// ==== source/bridge_fsm.sv ====
module bridge_fsm #(
    parameter int BEATS = core_axi_pkg::BEATS_DEFAULT
) (
    input  logic                       aclk,
    input  logic                       rst,
    input  core_axi_pkg::line_rd_req_t icache_rd_i,
    input  core_axi_pkg::line_rd_req_t dcache_rd_i,
    input  core_axi_pkg::line_wr_req_t dcache_wr_i,
    input  logic                       axi_arready_i,
    input  logic                       axi_awready_i,
    input  logic                       axi_wready_i,
    input  core_axi_pkg::axi_r_t       axi_r_i,
    input  core_axi_pkg::axi_b_t       axi_b_i,
    input  logic                       last_beat_i,
    output core_axi_pkg::axi_ar_t      axi_ar_o,
    output core_axi_pkg::axi_aw_t      axi_aw_o,
    output logic                       w_valid_o,
    output logic                       axi_rready_o,
    output logic                       axi_bready_o,
    output logic                       beat_o,
    output logic                       clear_o,
    output logic                       load_o,
    output logic                       icache_ret_o,
    output logic                       dcache_ret_o,
    output logic                       wr_done_o
);
    localparam int LINE_BYTES = BEATS * ($bits(core_axi_pkg::word_t) / 8);
    localparam core_axi_pkg::addr_t LINE_MASK = ~core_axi_pkg::addr_t'(LINE_BYTES - 1);

    typedef enum logic [2:0] {S_IDLE, S_AR, S_R, S_AW, S_W, S_B, S_RET} state_t;
    typedef enum logic [1:0] {G_WR, G_DRD, G_IRD} grant_t;

    state_t                  state_q;
    state_t                  state_d;
    grant_t                  grant_q;
    grant_t                  grant_d;
    logic                    start;
    core_axi_pkg::addr_t     req_addr;
    core_axi_pkg::addr_t     addr_q;
    core_axi_pkg::axi_id_t   id_q;

    always_comb begin
        state_d = state_q;
        grant_d = grant_q;
        case (state_q)
            S_IDLE: begin
                // write-back first, then dcache refill, then icache
                if (dcache_wr_i.req) begin
                    grant_d = G_WR;
                    state_d = S_AW;
                end else if (dcache_rd_i.req) begin
                    grant_d = G_DRD;
                    state_d = S_AR;
                end else if (icache_rd_i.req) begin
                    grant_d = G_IRD;
                    state_d = S_AR;
                end
            end
            S_AR:    if (axi_arready_i) state_d = S_R;
            S_R:     if (axi_r_i.valid && last_beat_i) state_d = S_RET;
            S_AW:    if (axi_awready_i) state_d = S_W;
            S_W:     if (axi_wready_i && last_beat_i) state_d = S_B;
            S_B:     if (axi_b_i.valid) state_d = S_RET;
            S_RET:   state_d = S_IDLE; // requester drops req meanwhile
            default: state_d = S_IDLE;
        endcase
    end

    always_comb begin
        case (grant_d)
            G_WR:    req_addr = dcache_wr_i.addr;
            G_DRD:   req_addr = dcache_rd_i.addr;
            default: req_addr = icache_rd_i.addr;
        endcase
    end

    assign start = (state_q == S_IDLE) && (state_d != S_IDLE);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q <= S_IDLE;
            grant_q <= G_IRD;
        end else begin
            state_q <= state_d;
            grant_q <= grant_d;
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            addr_q <= req_addr & LINE_MASK;
            id_q   <= (grant_d == G_IRD) ? core_axi_pkg::ID_ICACHE : core_axi_pkg::ID_DCACHE;
        end
    end

    always_comb begin
        axi_ar_o.valid = (state_q == S_AR);
        axi_ar_o.id    = id_q;
        axi_ar_o.addr  = addr_q;
        axi_aw_o.valid = (state_q == S_AW);
        axi_aw_o.id    = core_axi_pkg::ID_DCACHE; // only dcache writes
        axi_aw_o.addr  = addr_q;
    end

    assign w_valid_o    = (state_q == S_W);
    assign axi_rready_o = (state_q == S_R);
    assign axi_bready_o = (state_q == S_B);

    // transfer on whichever data channel is active
    assign beat_o = (axi_rready_o && axi_r_i.valid) || (w_valid_o && axi_wready_i);

    assign clear_o = start;
    assign load_o  = start && (grant_d == G_WR);

    assign icache_ret_o = (state_q == S_RET) && (grant_q == G_IRD);
    assign dcache_ret_o = (state_q == S_RET) && (grant_q == G_DRD);
    assign wr_done_o    = (state_q == S_RET) && (grant_q == G_WR);

endmodule

// ==== source/axi_cache_bridge.sv ====
module axi_cache_bridge #(
    parameter int BEATS = core_axi_pkg::BEATS_DEFAULT
) (
    input  logic                       aclk,
    input  logic                       rst,
    // cache side
    input  core_axi_pkg::line_rd_req_t icache_rd_i,
    input  core_axi_pkg::line_rd_req_t dcache_rd_i,
    input  core_axi_pkg::line_wr_req_t dcache_wr_i,
    output core_axi_pkg::line_ret_t    icache_rd_o,
    output core_axi_pkg::line_ret_t    dcache_rd_o,
    output logic                       dcache_wr_done_o,
    // axi master
    output core_axi_pkg::axi_ar_t      axi_ar_o,
    input  logic                       axi_arready_i,
    input  core_axi_pkg::axi_r_t       axi_r_i,
    output logic                       axi_rready_o,
    output core_axi_pkg::axi_aw_t      axi_aw_o,
    input  logic                       axi_awready_i,
    output core_axi_pkg::axi_w_t       axi_w_o,
    input  logic                       axi_wready_i,
    input  core_axi_pkg::axi_b_t       axi_b_i,
    output logic                       axi_bready_o
);
    localparam int LINE_W = BEATS * $bits(core_axi_pkg::word_t);

    logic                last_beat;
    logic                beat;
    logic                clear;
    logic                load;
    logic                w_valid;
    logic                icache_ret;
    logic                dcache_ret;
    logic                read_beat;
    logic                write_beat;
    logic [LINE_W-1:0]   rd_line;
    core_axi_pkg::word_t wdata;

    assign read_beat  = beat & axi_rready_o; // beat strobe split per channel
    assign write_beat = beat & w_valid;

    bridge_fsm #(.BEATS(BEATS)) fsm_i (
        .aclk          (aclk),
        .rst           (rst),
        .icache_rd_i   (icache_rd_i),
        .dcache_rd_i   (dcache_rd_i),
        .dcache_wr_i   (dcache_wr_i),
        .axi_arready_i (axi_arready_i),
        .axi_awready_i (axi_awready_i),
        .axi_wready_i  (axi_wready_i),
        .axi_r_i       (axi_r_i),
        .axi_b_i       (axi_b_i),
        .last_beat_i   (last_beat),
        .axi_ar_o      (axi_ar_o),
        .axi_aw_o      (axi_aw_o),
        .w_valid_o     (w_valid),
        .axi_rready_o  (axi_rready_o),
        .axi_bready_o  (axi_bready_o),
        .beat_o        (beat),
        .clear_o       (clear),
        .load_o        (load),
        .icache_ret_o  (icache_ret),
        .dcache_ret_o  (dcache_ret),
        .wr_done_o     (dcache_wr_done_o)
    );

    beat_counter #(.BEATS(BEATS)) counter_i (
        .aclk        (aclk),
        .rst         (rst),
        .clear_i     (clear),
        .beat_i      (beat),
        .last_beat_o (last_beat)
    );

    rd_line_assembler #(.BEATS(BEATS)) assembler_i (
        .aclk      (aclk),
        .rst       (rst),
        .capture_i (read_beat),
        .rdata_i   (axi_r_i.data),
        .line_o    (rd_line)
    );

    wr_line_serializer #(.BEATS(BEATS)) serializer_i (
        .aclk      (aclk),
        .rst       (rst),
        .load_i    (load),
        .line_i    (dcache_wr_i.data),
        .advance_i (write_beat),
        .wdata_o   (wdata)
    );

    // one line buffer serves both refill paths
    assign icache_rd_o = core_axi_pkg::line_ret_t'{valid: icache_ret, data: rd_line};
    assign dcache_rd_o = core_axi_pkg::line_ret_t'{valid: dcache_ret, data: rd_line};

    assign axi_w_o = core_axi_pkg::axi_w_t'{
        valid: w_valid,
        data:  wdata,
        last:  w_valid & last_beat
    };

endmodule

// ==== sim/axi_slave_model.sv ====
module axi_slave_model #(
    parameter int          BEATS = core_axi_pkg::BEATS_DEFAULT,
    parameter logic [31:0] SEED  = 32'd1
) (
    input  logic                  aclk,
    input  logic                  rst,
    input  core_axi_pkg::axi_ar_t axi_ar_i,
    output logic                  axi_arready_o,
    output core_axi_pkg::axi_r_t  axi_r_o,
    input  logic                  axi_rready_i,
    input  core_axi_pkg::axi_aw_t axi_aw_i,
    output logic                  axi_awready_o,
    input  core_axi_pkg::axi_w_t  axi_w_i,
    output logic                  axi_wready_o,
    output core_axi_pkg::axi_b_t  axi_b_o,
    input  logic                  axi_bready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    core_axi_pkg::word_t   mem [core_axi_pkg::addr_t]; // written words only
    core_axi_pkg::addr_t   rd_addr;
    core_axi_pkg::addr_t   wr_addr;
    core_axi_pkg::axi_id_t rd_id;
    core_axi_pkg::axi_id_t wr_id;
    int                    rd_left;
    logic                  resp_due;

    function automatic core_axi_pkg::word_t read_word(input core_axi_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a_5a5a; // fill pattern
    endfunction

    initial begin
        logic in_reset;
        logic r_keep;
        logic b_keep;
        void'($urandom(SEED));
        in_reset      = 1'b1;
        r_keep        = 1'b0;
        b_keep        = 1'b0;
        rd_addr       = '0;
        wr_addr       = '0;
        rd_id         = '0;
        wr_id         = '0;
        rd_left       = 0;
        resp_due      = 1'b0;
        axi_arready_o = 1'b0;
        axi_awready_o = 1'b0;
        axi_wready_o  = 1'b0;
        axi_r_o       = '0;
        axi_b_o       = '0;
        forever begin
            // handshakes sampled mid-cycle, inputs settled there
            @(negedge aclk);
            in_reset = rst;
            if (in_reset) begin
                rd_left  = 0;
                resp_due = 1'b0;
            end else begin
                if (axi_ar_i.valid && axi_arready_o) begin
                    rd_addr = axi_ar_i.addr;
                    rd_id   = axi_ar_i.id;
                    rd_left = BEATS;
                end
                if (axi_r_o.valid && axi_rready_i) begin
                    rd_addr = rd_addr + 32'd4; // incrementing burst
                    rd_left = rd_left - 1;
                end
                if (axi_aw_i.valid && axi_awready_o) begin
                    wr_addr = axi_aw_i.addr;
                    wr_id   = axi_aw_i.id;
                end
                if (axi_w_i.valid && axi_wready_o) begin
                    mem[wr_addr] = axi_w_i.data;
                    wr_addr      = wr_addr + 32'd4;
                    if (axi_w_i.last) begin
                        resp_due = 1'b1;
                    end
                end
                if (axi_b_o.valid && axi_bready_i) begin
                    resp_due = 1'b0;
                end
            end
            r_keep = axi_r_o.valid && !axi_rready_i && !in_reset; // valid held until taken
            b_keep = axi_b_o.valid && !axi_bready_i && !in_reset;
            @(posedge aclk);
            #1;
            axi_arready_o = !in_reset && ($urandom_range(3) != 0);
            axi_awready_o = !in_reset && ($urandom_range(3) != 0);
            axi_wready_o  = !in_reset && ($urandom_range(3) != 0);
            axi_r_o = '{
                valid: r_keep || ((rd_left > 0) && ($urandom_range(3) != 0)),
                id:    rd_id,
                data:  read_word(rd_addr),
                resp:  2'b00,
                last:  (rd_left == 1)
            };
            axi_b_o = '{
                valid: b_keep || (resp_due && ($urandom_range(2) != 0)),
                id:    wr_id,
                resp:  2'b00
            };
        end
    end

endmodule

// ==== sim/tb_axi_cache_bridge.sv ====
module tb_axi_cache_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BEATS            = core_axi_pkg::BEATS_DEFAULT;
    localparam int CLK_NS           = 100;
    localparam int N_TRANS          = 40;
    localparam int CYCLES_PER_TRANS = 60;
    localparam int LINE_BYTES       = BEATS * 4;
    localparam core_axi_pkg::addr_t LINE_MASK = ~core_axi_pkg::addr_t'(LINE_BYTES - 1);

    logic                       aclk;
    logic                       rst;
    core_axi_pkg::line_rd_req_t icache_rd;
    core_axi_pkg::line_rd_req_t dcache_rd;
    core_axi_pkg::line_wr_req_t dcache_wr;
    core_axi_pkg::line_ret_t    icache_ret;
    core_axi_pkg::line_ret_t    dcache_ret;
    logic                       wr_done;
    core_axi_pkg::axi_ar_t      axi_ar;
    core_axi_pkg::axi_aw_t      axi_aw;
    core_axi_pkg::axi_w_t       axi_w;
    core_axi_pkg::axi_r_t       axi_r;
    core_axi_pkg::axi_b_t       axi_b;
    logic                       arready;
    logic                       awready;
    logic                       wready;
    logic                       rready;
    logic                       bready;

    int                    errors;
    int                    transactions;
    int                    w_count;
    core_axi_pkg::word_t   shadow [core_axi_pkg::addr_t]; // lines written so far
    core_axi_pkg::axi_id_t last_ar_id;
    core_axi_pkg::addr_t   last_ar_addr;
    logic [4:0]            xfer_order [$]; // {is_aw, id} per address transfer

    axi_cache_bridge #(.BEATS(BEATS)) dut_i (
        .aclk             (aclk),
        .rst              (rst),
        .icache_rd_i      (icache_rd),
        .dcache_rd_i      (dcache_rd),
        .dcache_wr_i      (dcache_wr),
        .icache_rd_o      (icache_ret),
        .dcache_rd_o      (dcache_ret),
        .dcache_wr_done_o (wr_done),
        .axi_ar_o         (axi_ar),
        .axi_arready_i    (arready),
        .axi_r_i          (axi_r),
        .axi_rready_o     (rready),
        .axi_aw_o         (axi_aw),
        .axi_awready_i    (awready),
        .axi_w_o          (axi_w),
        .axi_wready_i     (wready),
        .axi_b_i          (axi_b),
        .axi_bready_o     (bready)
    );

    axi_slave_model #(.BEATS(BEATS), .SEED(32'hfe05_de1e)) slave_i (
        .aclk          (aclk),
        .rst           (rst),
        .axi_ar_i      (axi_ar),
        .axi_arready_o (arready),
        .axi_r_o       (axi_r),
        .axi_rready_i  (rready),
        .axi_aw_i      (axi_aw),
        .axi_awready_o (awready),
        .axi_w_i       (axi_w),
        .axi_wready_o  (wready),
        .axi_b_o       (axi_b),
        .axi_bready_i  (bready)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_NS / 2) aclk = ~aclk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR %s at %0t", what, $time);
    endtask

    function automatic core_axi_pkg::word_t expected_word(input core_axi_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'h5a5a_5a5a;
    endfunction

    function automatic core_axi_pkg::line_t make_line(input int tag);
        core_axi_pkg::line_t line;
        int i;
        for (i = 0; i < BEATS; i++) begin
            line[32*i +: 32] = 32'hc0de_0000 + 32'(tag * 16 + i);
        end
        return line;
    endfunction

    task automatic read_line(input logic is_icache, input core_axi_pkg::addr_t addr);
        core_axi_pkg::addr_t     base;
        core_axi_pkg::axi_id_t   exp_id;
        core_axi_pkg::line_ret_t ret;
        int i;
        base   = addr & LINE_MASK;
        exp_id = is_icache ? core_axi_pkg::ID_ICACHE : core_axi_pkg::ID_DCACHE;
        @(posedge aclk);
        #1;
        if (is_icache) begin
            icache_rd = '{req: 1'b1, addr: addr};
        end else begin
            dcache_rd = '{req: 1'b1, addr: addr};
        end
        do begin
            @(negedge aclk);
            ret = is_icache ? icache_ret : dcache_ret;
        end while (!ret.valid);
        // one burst in flight, so the last AR belongs to this line
        assert (last_ar_id == exp_id)
            else report_mismatch("axi_ar_o.id", 64'(last_ar_id), 64'(exp_id));
        assert (last_ar_addr == base)
            else report_mismatch("axi_ar_o.addr", 64'(last_ar_addr), 64'(base));
        for (i = 0; i < BEATS; i++) begin
            assert (ret.data[32*i +: 32] == expected_word(base + 32'(4 * i)))
                else report_mismatch($sformatf("%s.data[%0d]",
                                               is_icache ? "icache_rd_o" : "dcache_rd_o", i),
                                     64'(ret.data[32*i +: 32]),
                                     64'(expected_word(base + 32'(4 * i))));
        end
        @(posedge aclk);
        #1;
        if (is_icache) begin
            icache_rd.req = 1'b0;
        end else begin
            dcache_rd.req = 1'b0;
        end
        transactions++;
    endtask

    task automatic write_line(input core_axi_pkg::addr_t addr, input core_axi_pkg::line_t data);
        int i;
        @(posedge aclk);
        #1;
        dcache_wr = '{req: 1'b1, addr: addr, data: data};
        do begin
            @(negedge aclk);
        end while (!wr_done);
        assert (w_count == BEATS)
            else report_mismatch("write beat count", 64'(w_count), 64'(BEATS));
        for (i = 0; i < BEATS; i++) begin
            shadow[(addr & LINE_MASK) + 32'(4 * i)] = data[32*i +: 32];
        end
        @(posedge aclk);
        #1;
        dcache_wr.req = 1'b0;
        transactions++;
    endtask

    // bus monitor sampled mid-cycle
    initial begin
        core_axi_pkg::axi_ar_t ar_prev;
        core_axi_pkg::axi_aw_t aw_prev;
        core_axi_pkg::axi_w_t  w_prev;
        logic ar_held;
        logic aw_held;
        logic w_held;
        ar_held = 1'b0;
        aw_held = 1'b0;
        w_held  = 1'b0;
        forever begin
            @(negedge aclk);
            if (!rst) begin
                // a stalled channel must not change until taken
                if (ar_held) assert (axi_ar == ar_prev)
                    else report_mismatch("axi_ar_o while stalled", 64'(axi_ar), 64'(ar_prev));
                if (aw_held) assert (axi_aw == aw_prev)
                    else report_mismatch("axi_aw_o while stalled", 64'(axi_aw), 64'(aw_prev));
                if (w_held) assert (axi_w == w_prev)
                    else report_mismatch("axi_w_o while stalled", 64'(axi_w), 64'(w_prev));
                if (axi_ar.valid && arready) begin
                    last_ar_id   = axi_ar.id;
                    last_ar_addr = axi_ar.addr;
                    xfer_order.push_back({1'b0, axi_ar.id});
                end
                if (axi_aw.valid && awready) begin
                    assert (axi_aw.id == core_axi_pkg::ID_DCACHE)
                        else report_mismatch("axi_aw_o.id", 64'(axi_aw.id),
                                             64'(core_axi_pkg::ID_DCACHE));
                    assert (axi_aw.addr == (dcache_wr.addr & LINE_MASK))
                        else report_mismatch("axi_aw_o.addr", 64'(axi_aw.addr),
                                             64'(dcache_wr.addr & LINE_MASK));
                    w_count = 0;
                    xfer_order.push_back({1'b1, axi_aw.id});
                end
                if (axi_w.valid && wready) begin
                    if (w_count < BEATS) begin
                        assert (axi_w.data == dcache_wr.data[32*w_count +: 32])
                            else report_mismatch("axi_w_o.data", 64'(axi_w.data),
                                                 64'(dcache_wr.data[32*w_count +: 32]));
                        assert (axi_w.last == (w_count == BEATS - 1))
                            else report_mismatch("axi_w_o.last", 64'(axi_w.last),
                                                 64'(w_count == BEATS - 1));
                    end else begin
                        report_error("write burst carried more beats than one line");
                    end
                    w_count++;
                end
            end
            ar_held = !rst && axi_ar.valid && !arready;
            aw_held = !rst && axi_aw.valid && !awready;
            w_held  = !rst && axi_w.valid && !wready;
            ar_prev = axi_ar;
            aw_prev = axi_aw;
            w_prev  = axi_w;
        end
    end

    initial begin
        #(N_TRANS * CYCLES_PER_TRANS * CLK_NS);
        $display("watchdog expired, transactions stopped completing after %0d", transactions);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [7:0]          idle_vec;
        logic [4:0]          order_exp [3];
        core_axi_pkg::addr_t addr;
        int i;
        rst          = 1'b1;
        icache_rd    = '{req: 1'b1, addr: 32'h0000_1004}; // pending through reset
        dcache_rd    = '0;
        dcache_wr    = '0;
        errors       = 0;
        transactions = 0;
        w_count      = 0;
        last_ar_id   = '0;
        last_ar_addr = '0;
        repeat (2) @(posedge aclk);
        #1;
        rst           = 1'b0;
        icache_rd.req = 1'b0;
        @(negedge aclk);
        idle_vec = {axi_ar.valid, axi_aw.valid, axi_w.valid, rready, bready,
                    icache_ret.valid, dcache_ret.valid, wr_done};
        assert (idle_vec == 8'h00)
            else report_mismatch("valids/readies/returns after reset", 64'(idle_vec), 64'h0);

        read_line(1'b1, 32'h0000_1004);
        read_line(1'b0, 32'h0000_1020);
        write_line(32'h0000_1020, make_line(1));
        read_line(1'b0, 32'h0000_103c); // same line holds the written data now

        // all three raised together
        order_exp[0] = {1'b1, core_axi_pkg::ID_DCACHE};
        order_exp[1] = {1'b0, core_axi_pkg::ID_DCACHE};
        order_exp[2] = {1'b0, core_axi_pkg::ID_ICACHE};
        xfer_order.delete();
        fork
            write_line(32'h0000_2040, make_line(2));
            read_line(1'b0, 32'h0000_3064);
            read_line(1'b1, 32'h0000_4008);
        join
        if (xfer_order.size() == 3) begin
            for (i = 0; i < 3; i++) begin
                assert (xfer_order[i] == order_exp[i])
                    else report_mismatch($sformatf("address transfer %0d {is_aw,id}", i),
                                         64'(xfer_order[i]), 64'(order_exp[i]));
            end
        end else begin
            report_error("priority test saw the wrong number of address transfers");
        end

        for (i = 0; i < 30; i++) begin
            addr = 32'h0001_0000 + 32'(((i * 7) % 8) * LINE_BYTES + (i % 8) * 4);
            case (i % 3)
                0:       write_line(addr, make_line(i + 3));
                1:       read_line(1'b0, addr);
                default: read_line(1'b1, addr);
            endcase
        end

        $display("transactions: %0d, errors: %0d", transactions, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/core_axi_pkg.sv
source/beat_counter.sv
source/rd_line_assembler.sv
source/wr_line_serializer.sv
source/bridge_fsm.sv
source/axi_cache_bridge.sv
sim/axi_slave_model.sv
sim/tb_axi_cache_bridge.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axi_cache_bridge \
    -f vlog.f -Mdir obj_dir -o sim_axi_cache_bridge

./obj_dir/sim_axi_cache_bridge | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
